//--- verilog.f
hdl/memSysPkg.sv
hdl/instrCache.sv
hdl/dataCache.sv
hdl/busArbiter.sv
hdl/busMemory.sv
hdl/memSystem.sv
testbench/memSystemTb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory system testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module memSystemTb -o memSystemSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/memSystemSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "^TEST PASS$"; then
  exit 0
fi
exit 1

//--- testbench/memSystemTb.sv
`timescale 1ns/10ps

module memSystemTb
  import memSysPkg::*;
();

  // Must match the DUT defaults
  localparam int lineCount = 16;
  localparam int modelWords = 64;
  localparam int timeoutCycles = 200;

  logic     clk;
  logic     rst;
  logic     fetchValid;
  addrT     fetchAddr;
  logic     dataReq;
  logic     dataWrite;
  addrT     dataAddr;
  wordT     dataWdata;
  byteMaskT dataMask;
  logic     iFlush;
  logic     dFlush;
  wordT     instr;
  logic     iStall;
  wordT     readData;
  logic     dStall;

  // Reference model of the memory plus a copy of each cache
  wordT memModel [modelWords];
  logic icValid [lineCount];
  int   icWord [lineCount];
  wordT icData [lineCount];
  logic dcValid [lineCount];
  int   dcWord [lineCount];
  wordT dcData [lineCount];

  int   seed;
  int   checkCount;
  int   errCount;
  logic hung = 1'b0;

  memSystem i_memSystem (
    .clk(clk), .rst(rst), .fetchValid(fetchValid), .fetchAddr(fetchAddr),
    .dataReq(dataReq), .dataWrite(dataWrite), .dataAddr(dataAddr),
    .dataWdata(dataWdata), .dataMask(dataMask), .iFlush(iFlush), .dFlush(dFlush),
    .instr(instr), .iStall(iStall), .readData(readData), .dStall(dStall));

  always #20 clk = ~clk;

  // Ends the run when a port stays stalled too long
  initial begin
    @(posedge hung);
    $display("TEST FAIL");
    $finish;
  end

  function automatic int randBelow(input int limit);
    logic [31:0] bits;
    bits = $random(seed);
    return int'(bits % limit);
  endfunction

  // Byte lanes with a set mask bit take the new value
  function automatic wordT mergeBytes(input wordT oldWord, input wordT newWord,
                                      input byteMaskT mask);
    wordT merged;
    merged = oldWord;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        merged[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return merged;
  endfunction

  task automatic initModel();
    // Power-up word is the inverse of its byte address
    for (int i = 0; i < modelWords; i++) begin
      memModel[i] = ~addrT'(4 * i);
    end
    for (int i = 0; i < lineCount; i++) begin
      icValid[i] = 1'b0;
      dcValid[i] = 1'b0;
    end
  endtask

  task automatic checkWord(input string sigName, input wordT got, input wordT exp,
                           input int word);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("CHECK FAILED %s got %h expected %h (word %0d, %0t)",
               sigName, got, exp, word, $time);
    end
  endtask

  task automatic checkBit(input string sigName, input logic got, input logic exp,
                          input int word);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("CHECK FAILED %s got %h expected %h (word %0d, %0t)",
               sigName, got, exp, word, $time);
    end
  endtask

  task automatic reportHang(input string portName, input int word);
    $display("%s access to word %0d still stalled after %0d cycles",
             portName, word, timeoutCycles);
    hung = 1'b1;
  endtask

  // One fetch starts at a drive point and returns at the next one
  task automatic fetchOp(input int word, output wordT gotWord, output logic stalled);
    int   idx;
    int   cycles;
    logic expHit;
    wordT expWord;
    idx = word % lineCount;
    expHit = icValid[idx] && (icWord[idx] == word);
    fetchValid = 1'b1;
    fetchAddr = addrT'(4 * word);
    @(negedge clk);
    stalled = iStall;
    // First cycle stalls exactly on a model miss
    checkBit("iStall", iStall, !expHit, word);
    cycles = 0;
    while (iStall && cycles < timeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (iStall) begin
      reportHang("fetch", word);
    end
    if (expHit) begin
      expWord = icData[idx];
    end else begin
      expWord = memModel[word];
      icValid[idx] = 1'b1;
      icWord[idx] = word;
      icData[idx] = expWord;
    end
    gotWord = instr;
    checkWord("instr", instr, expWord, word);
    @(posedge clk);
    #2;
  endtask

  // One data access with the same timing as fetchOp
  task automatic dataOp(input logic wr, input int word, input wordT wdata,
                        input byteMaskT mask, output wordT gotWord, output logic stalled);
    int   idx;
    int   cycles;
    logic expHit;
    wordT expWord;
    idx = word % lineCount;
    expHit = dcValid[idx] && (dcWord[idx] == word);
    dataReq = 1'b1;
    dataWrite = wr;
    dataAddr = addrT'(4 * word);
    dataWdata = wdata;
    dataMask = mask;
    @(negedge clk);
    stalled = dStall;
    // Writes always stall and reads stall only on a miss
    checkBit("dStall", dStall, wr || !expHit, word);
    cycles = 0;
    while (dStall && cycles < timeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (dStall) begin
      reportHang("data", word);
    end
    gotWord = readData;
    if (wr) begin
      // Write-through with no allocate on a miss
      memModel[word] = mergeBytes(memModel[word], wdata, mask);
      if (expHit) begin
        dcData[idx] = mergeBytes(dcData[idx], wdata, mask);
      end
    end else begin
      if (expHit) begin
        expWord = dcData[idx];
      end else begin
        expWord = memModel[word];
        dcValid[idx] = 1'b1;
        dcWord[idx] = word;
        dcData[idx] = expWord;
      end
      checkWord("readData", readData, expWord, word);
    end
    @(posedge clk);
    #2;
  endtask

  task automatic pulseIFlush();
    iFlush = 1'b1;
    @(posedge clk);
    #2;
    iFlush = 1'b0;
    for (int i = 0; i < lineCount; i++) begin
      icValid[i] = 1'b0;
    end
  endtask

  task automatic pulseDFlush();
    dFlush = 1'b1;
    @(posedge clk);
    #2;
    dFlush = 1'b0;
    for (int i = 0; i < lineCount; i++) begin
      dcValid[i] = 1'b0;
    end
  endtask

  task automatic reportTest(input string testName, input int errBefore);
    $display("test %s finished with %0d errors", testName, errCount - errBefore);
  endtask

  initial begin
    wordT     got;
    logic     stalled;
    wordT     oldWord;
    wordT     newWord;
    byteMaskT mask;
    int       word;
    int       errBefore;
    seed = 32'h2dbd_5b3f;
    clk = 1'b0;
    rst = 1'b1;
    fetchValid = 1'b0;
    fetchAddr = '0;
    dataReq = 1'b0;
    dataWrite = 1'b0;
    dataAddr = '0;
    dataWdata = '0;
    dataMask = '0;
    iFlush = 1'b0;
    dFlush = 1'b0;
    checkCount = 0;
    errCount = 0;
    initModel();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    // Random fetches hit and miss on aliasing lines
    errBefore = errCount;
    repeat (200) begin
      fetchOp(randBelow(modelWords), got, stalled);
    end
    fetchValid = 1'b0;
    reportTest("fetch random", errBefore);

    // Random masked writes mixed with reads
    errBefore = errCount;
    repeat (200) begin
      word = randBelow(modelWords);
      newWord = $random(seed);
      mask = byteMaskT'($random(seed));
      dataOp(randBelow(2) == 1, word, newWord, mask, got, stalled);
    end
    // Write and read back, then evict through the aliased word
    repeat (16) begin
      word = randBelow(modelWords);
      newWord = $random(seed);
      mask = byteMaskT'($random(seed));
      dataOp(1'b1, word, newWord, mask, got, stalled);
      dataOp(1'b0, word, '0, '0, got, stalled);
      dataOp(1'b0, (word + lineCount) % modelWords, '0, '0, got, stalled);
      checkBit("dStall", stalled, 1'b1, (word + lineCount) % modelWords);
      dataOp(1'b0, word, '0, '0, got, stalled);
    end
    dataReq = 1'b0;
    reportTest("masked write-through", errBefore);

    // Instruction line stays stale until iFlush
    errBefore = errCount;
    word = randBelow(modelWords);
    fetchOp(word, got, stalled);
    fetchOp(word, got, stalled);
    // Stale value is the model's copy of the cached line
    oldWord = icData[word % lineCount];
    newWord = $random(seed);
    if (newWord == oldWord) begin
      newWord = ~newWord;
    end
    fetchValid = 1'b0;
    dataOp(1'b1, word, newWord, 4'hf, got, stalled);
    dataReq = 1'b0;
    fetchOp(word, got, stalled);
    checkWord("instr", got, oldWord, word);
    fetchValid = 1'b0;
    pulseIFlush();
    fetchOp(word, got, stalled);
    checkBit("iStall", stalled, 1'b1, word);
    checkWord("instr", got, newWord, word);
    fetchValid = 1'b0;
    reportTest("stale instruction and flush", errBefore);

    // dFlush forces a refill of a cached word
    errBefore = errCount;
    word = randBelow(modelWords);
    dataOp(1'b0, word, '0, '0, got, stalled);
    dataOp(1'b0, word, '0, '0, got, stalled);
    checkBit("dStall", stalled, 1'b0, word);
    dataReq = 1'b0;
    pulseDFlush();
    dataOp(1'b0, word, '0, '0, got, stalled);
    checkBit("dStall", stalled, 1'b1, word);
    checkWord("readData", got, memModel[word], word);
    dataReq = 1'b0;
    reportTest("data flush", errBefore);

    // Both ports run at once with fetches in the upper half and data in the lower half
    errBefore = errCount;
    fork
      begin : fetchThread
        wordT fGot;
        logic fStalled;
        repeat (500) begin
          fetchOp(modelWords / 2 + randBelow(modelWords / 2), fGot, fStalled);
        end
        fetchValid = 1'b0;
      end
      begin : dataThread
        wordT     dGot;
        logic     dStalled;
        wordT     dWdata;
        byteMaskT dMask;
        repeat (500) begin
          dWdata = $random(seed);
          dMask = byteMaskT'($random(seed));
          dataOp(randBelow(2) == 1, randBelow(modelWords / 2), dWdata, dMask,
                 dGot, dStalled);
        end
        dataReq = 1'b0;
      end
    join
    reportTest("contention", errBefore);

    $display("checks passed %0d, errors %0d", checkCount - errCount, errCount);
    if (errCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- hdl/memSystem.sv
`timescale 1ns/10ps

module memSystem
  import memSysPkg::*;
#(
  parameter int lineCount = 16,
  parameter int waitStates = 2,
  parameter int memWords = 256
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     fetchValid,
  input  addrT     fetchAddr,
  input  logic     dataReq,
  input  logic     dataWrite,
  input  addrT     dataAddr,
  input  wordT     dataWdata,
  input  byteMaskT dataMask,
  input  logic     iFlush,
  input  logic     dFlush,
  output wordT     instr,
  output logic     iStall,
  output wordT     readData,
  output logic     dStall
);

  // Instruction cache to arbiter
  busReqT iBusReq;
  logic   iBusReqValid, iBusReady;
  wordT   iBusRdata;

  // Data cache to arbiter
  busReqT dBusReq;
  logic   dBusReqValid, dBusReady;
  wordT   dBusRdata;

  // Arbiter to memory
  busReqT memReq;
  logic   memReqValid, memReady;
  wordT   memRdata;

  instrCache #(.lineCount(lineCount)) i_instrCache (
    .clk(clk), .rst(rst), .fetchValid(fetchValid), .fetchAddr(fetchAddr),
    .flush(iFlush), .busRdata(iBusRdata), .busReady(iBusReady),
    .instr(instr), .iStall(iStall), .busReq(iBusReq), .busReqValid(iBusReqValid));

  dataCache #(.lineCount(lineCount)) i_dataCache (
    .clk(clk), .rst(rst), .dataReq(dataReq), .dataWrite(dataWrite),
    .dataAddr(dataAddr), .dataWdata(dataWdata), .dataMask(dataMask),
    .flush(dFlush), .busRdata(dBusRdata), .busReady(dBusReady),
    .readData(readData), .dStall(dStall), .busReq(dBusReq), .busReqValid(dBusReqValid));

  busArbiter i_busArbiter (
    .clk(clk), .rst(rst), .iReq(iBusReq), .iReqValid(iBusReqValid),
    .dReq(dBusReq), .dReqValid(dBusReqValid), .memRdata(memRdata), .memReady(memReady),
    .iRdata(iBusRdata), .iReady(iBusReady), .dRdata(dBusRdata), .dReady(dBusReady),
    .memReq(memReq), .memReqValid(memReqValid));

  busMemory #(.waitStates(waitStates), .memWords(memWords)) i_busMemory (
    .clk(clk), .rst(rst), .req(memReq), .reqValid(memReqValid),
    .rdata(memRdata), .ready(memReady));

endmodule

//--- hdl/busMemory.sv
`timescale 1ns/10ps

module busMemory
  import memSysPkg::*;
#(
  parameter int waitStates = 2,
  parameter int memWords = 256
) (
  input  logic   clk,
  input  logic   rst,
  input  busReqT req,
  input  logic   reqValid,
  output wordT   rdata,
  output logic   ready
);

  localparam int memIdxW = $clog2(memWords);
  localparam int cntW = (waitStates > 0) ? $clog2(waitStates + 1) : 1;

  typedef logic [memIdxW-1:0] wordIdxT;
  typedef logic [cntW-1:0] waitCntT;

  wordT    mem [memWords];
  wordIdxT wordIdx;
  waitCntT waitCnt;
  logic    lastWait;

  // Word index, address bits beyond the depth wrap around
  assign wordIdx = req.addr[2 +: memIdxW];

  // Final wait cycle, the access happens on its closing edge
  assign lastWait = reqValid && !ready && (waitCnt == waitCntT'(waitStates));

  initial begin
    for (int i = 0; i < memWords; i++) begin
      mem[i] = memInitWord(addrT'(4 * i));
    end
  end

  // Wait counter and the one-cycle ready pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      waitCnt <= '0;
      ready <= 1'b0;
    end else if (ready) begin
      ready <= 1'b0;
    end else if (lastWait) begin
      ready <= 1'b1;
      waitCnt <= '0;
    end else if (reqValid) begin
      waitCnt <= waitCnt + 1'b1;
    end else begin
      waitCnt <= '0;
    end
  end

  // Array access, byte lanes written under the mask
  always @(posedge clk) begin
    if (lastWait) begin
      rdata <= mem[wordIdx];
      if (req.write) begin
        for (int b = 0; b < 4; b++) begin
          if (req.mask[b]) begin
            mem[wordIdx][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Requester keeps the request up until it sees ready
  holdReqA: assert property (@(posedge clk) disable iff (rst)
    reqValid && !ready |=> reqValid)
    else $error("busMemory: request dropped before ready");

endmodule

//--- hdl/busArbiter.sv
`timescale 1ns/10ps

module busArbiter
  import memSysPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  busReqT iReq,
  input  logic   iReqValid,
  input  busReqT dReq,
  input  logic   dReqValid,
  input  wordT   memRdata,
  input  logic   memReady,
  output wordT   iRdata,
  output logic   iReady,
  output wordT   dRdata,
  output logic   dReady,
  output busReqT memReq,
  output logic   memReqValid
);

  typedef enum logic [1:0] {
    grantNone,
    grantData,
    grantInstr
  } grantT;

  grantT grantQ;
  grantT owner;

  // A held grant wins and data goes before instruction on an idle bus
  always_comb begin
    if (grantQ != grantNone) begin
      owner = grantQ;
    end else if (dReqValid) begin
      owner = grantData;
    end else if (iReqValid) begin
      owner = grantInstr;
    end else begin
      owner = grantNone;
    end
  end

  assign memReq = (owner == grantInstr) ? iReq : dReq;
  assign memReqValid = ((owner == grantData) && dReqValid) ||
                       ((owner == grantInstr) && iReqValid);

  // Answer goes to the owner only
  assign dReady = memReady && (owner == grantData);
  assign iReady = memReady && (owner == grantInstr);
  assign dRdata = (owner == grantData) ? memRdata : '0;
  assign iRdata = (owner == grantInstr) ? memRdata : '0;

  // Ready releases the grant and the next owner is picked in the following cycle
  always_ff @(posedge clk) begin
    if (rst || memReady) begin
      grantQ <= grantNone;
    end else begin
      grantQ <= owner;
    end
  end

  // Every memory answer reaches exactly one cache
  oneReadyA: assert property (@(posedge clk) disable iff (rst)
    memReady |-> $onehot({iReady, dReady}))
    else $error("busArbiter: memory ready did not reach exactly one cache");

endmodule

//--- hdl/dataCache.sv
`timescale 1ns/10ps

module dataCache
  import memSysPkg::*;
#(
  parameter int lineCount = 16
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     dataReq,
  input  logic     dataWrite,
  input  addrT     dataAddr,
  input  wordT     dataWdata,
  input  byteMaskT dataMask,
  input  logic     flush,
  input  wordT     busRdata,
  input  logic     busReady,
  output wordT     readData,
  output logic     dStall,
  output busReqT   busReq,
  output logic     busReqValid
);

  // Same line layout as the instruction side
  localparam int indexW = $clog2(lineCount);
  localparam int tagW = 30 - indexW;

  typedef logic [indexW-1:0] indexT;
  typedef logic [tagW-1:0] tagT;

  tagT  tagArr [lineCount];
  wordT dataArr [lineCount];
  logic [lineCount-1:0] validArr;

  cacheStateT state;
  cacheStateT stateNext;

  indexT lineIdx;
  tagT   lineTag;
  logic  hit;
  logic  busDone;
  logic  needBus;

  assign lineIdx = dataAddr[2 +: indexW];
  assign lineTag = dataAddr[31 -: tagW];
  assign hit = validArr[lineIdx] && (tagArr[lineIdx] == lineTag);

  // Ready cycle of the current transaction
  assign busDone = (state == busWait) && busReady;

  // Writes always go to the bus, reads only on a miss
  assign needBus = dataReq && (dataWrite || !hit);

  assign readData = dataArr[lineIdx];

  // fill closes the access, so the stall drops there
  assign dStall = (state == busWait) || ((state == idle) && needBus);

  // Request follows the held core inputs
  assign busReqValid = (state == busWait);
  assign busReq.addr = {dataAddr[31:2], 2'b00};
  assign busReq.wdata = dataWdata;
  assign busReq.mask = dataWrite ? dataMask : '0;
  assign busReq.write = dataWrite;

  always_comb begin
    stateNext = state;
    case (state)
      idle: begin
        if (needBus) begin
          stateNext = busWait;
        end
      end
      busWait: begin
        if (busReady) begin
          stateNext = fill;
        end
      end
      default: begin
        stateNext = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= stateNext;
    end
  end

  // Only a read refill makes a line valid
  // write misses leave the array alone
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      validArr <= '0;
    end else if (busDone && !dataWrite) begin
      validArr[lineIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (busDone) begin
      if (!dataWrite) begin
        tagArr[lineIdx] <= lineTag;
        dataArr[lineIdx] <= busRdata;
      end else if (hit) begin
        // Merge the enabled lanes into the stored copy
        for (int b = 0; b < 4; b++) begin
          if (dataMask[b]) begin
            dataArr[lineIdx][8*b +: 8] <= dataWdata[8*b +: 8];
          end
        end
      end
    end
  end

  // A stall only ever holds back a pending core access
  stallNeedsReqA: assert property (@(posedge clk) disable iff (rst)
    dStall |-> dataReq)
    else $error("dataCache: dStall high with no data request");

endmodule

//--- hdl/instrCache.sv
`timescale 1ns/10ps

module instrCache
  import memSysPkg::*;
#(
  parameter int lineCount = 16
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   fetchValid,
  input  addrT   fetchAddr,
  input  logic   flush,
  input  wordT   busRdata,
  input  logic   busReady,
  output wordT   instr,
  output logic   iStall,
  output busReqT busReq,
  output logic   busReqValid
);

  // Word address bits above bit 1 select the line, the rest form the tag
  localparam int indexW = $clog2(lineCount);
  localparam int tagW = 30 - indexW;

  typedef logic [indexW-1:0] indexT;
  typedef logic [tagW-1:0] tagT;

  // Line storage, one word per line
  tagT  tagArr [lineCount];
  wordT dataArr [lineCount];
  logic [lineCount-1:0] validArr;

  cacheStateT state;
  cacheStateT stateNext;

  indexT lineIdx;
  tagT   lineTag;
  logic  hit;
  logic  refill;

  assign lineIdx = fetchAddr[2 +: indexW];
  assign lineTag = fetchAddr[31 -: tagW];
  assign hit = validArr[lineIdx] && (tagArr[lineIdx] == lineTag);

  // Line gets written on the edge that closes the ready cycle
  assign refill = (state == busWait) && busReady;

  // Hit path, also returns the fresh line during fill
  assign instr = dataArr[lineIdx];

  // Stall on a miss in idle and for the whole bus wait
  // fill is the completion cycle so the stall is already low
  assign iStall = (state == busWait) || ((state == idle) && fetchValid && !hit);

  // Read of the full word, the core holds fetchAddr while stalled
  assign busReqValid = (state == busWait);
  assign busReq.addr = {fetchAddr[31:2], 2'b00};
  assign busReq.wdata = '0;
  assign busReq.mask = '0;
  assign busReq.write = 1'b0;

  always_comb begin
    stateNext = state;
    case (state)
      idle: begin
        if (fetchValid && !hit) begin
          stateNext = busWait;
        end
      end
      busWait: begin
        if (busReady) begin
          stateNext = fill;
        end
      end
      default: begin
        stateNext = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= stateNext;
    end
  end

  // Valid bits, cleared by reset and by a flush strobe
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      validArr <= '0;
    end else if (refill) begin
      validArr[lineIdx] <= 1'b1;
    end
  end

  // Tag and data payload
  always_ff @(posedge clk) begin
    if (refill) begin
      tagArr[lineIdx] <= lineTag;
      dataArr[lineIdx] <= busRdata;
    end
  end

  // Core must keep the fetch address steady until the memory answers
  reqStableA: assert property (@(posedge clk) disable iff (rst)
    busReqValid && !busReady |=> $stable(busReq))
    else $error("instrCache: bus request changed while pending");

endmodule

//--- hdl/memSysPkg.sv
package memSysPkg;

  // Byte address, low two bits ignored since every access is a full word
  typedef logic [31:0] addrT;

  // One data word on the core side and on the bus
  typedef logic [31:0] wordT;

  // Byte lane write enables, bit 0 covers bits 7:0
  typedef logic [3:0] byteMaskT;

  // Request a cache hands to the arbiter, and the arbiter to the memory
  typedef struct packed {
    addrT     addr;
    wordT     wdata;
    byteMaskT mask;
    logic     write;
  } busReqT;

  // Miss handling states shared by both caches
  // idle    : lookup, a miss or a write leaves for busWait
  // busWait : bus request held until ready
  // fill    : completion cycle, stall released
  typedef enum logic [1:0] {
    idle,
    busWait,
    fill
  } cacheStateT;

  // Power-up content of a memory word
  // Inverse of its byte address, so every word differs from its neighbours
  function automatic wordT memInitWord(input addrT byteAddr);
    wordT initWord;
    initWord = ~byteAddr;
    return initWord;
  endfunction

endpackage
